//--- Makefile
TOP := tb_axi_mm_master_concat

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --top-module axi_mm_master_concat \
		hdl/llink_pkg.sv hdl/phy_pkg.sv hdl/llink_rr_arbiter.sv \
		hdl/tx_packetizer.sv hdl/rx_depacketizer.sv hdl/axi_mm_master_concat.sv

clean:
	rm -rf obj_dir

//--- hdl/axi_mm_master_concat.sv
////////////////////
// AXI-MM master logic-link concatenator
// Packs ar/aw/w onto the transmit PHY word and unpacks r/b
// and credits from the receive PHY word
////////////////////

module axi_mm_master_concat
  import llink_pkg::*;
  import phy_pkg::*;
#(
  // Boundary flops on the PHY words
  parameter bit TX_REG_PHY = 1'b1,
  parameter bit RX_REG_PHY = 1'b1
) (
  input  logic                 clk_rd,
  input  logic                 rst_rd_n,

  // Transmit logic links
  input  tx_llink_t            tx_ar,
  input  tx_llink_t            tx_aw,
  input  tx_llink_t            tx_w,
  output logic [NUM_TX_CH-1:0] tx_pop_ovrd,

  // Credits returned for r and b, plus marker
  input  logic                 tx_r_credit,
  input  logic                 tx_b_credit,
  input  logic                 tx_marker,

  // PHY side
  output phy_word_t            tx_phy,
  input  phy_word_t            rx_phy,

  // Receive logic links
  output rx_llink_t            rx_llink,
  output logic                 rx_ar_credit,
  output logic                 rx_aw_credit,
  output logic                 rx_w_credit
);

  ////////////////////
  // Transmit

  tx_packetizer #(
    .REG_PHY (TX_REG_PHY)
  ) u_tx_packetizer (
    .clk_rd      (clk_rd),
    .rst_rd_n    (rst_rd_n),
    .tx_ar       (tx_ar),
    .tx_aw       (tx_aw),
    .tx_w        (tx_w),
    .tx_r_credit (tx_r_credit),
    .tx_b_credit (tx_b_credit),
    .tx_marker   (tx_marker),
    .tx_pop_ovrd (tx_pop_ovrd),
    .tx_phy      (tx_phy)
  );

  ////////////////////
  // Receive

  rx_depacketizer #(
    .REG_PHY (RX_REG_PHY)
  ) u_rx_depacketizer (
    .clk_rd       (clk_rd),
    .rst_rd_n     (rst_rd_n),
    .rx_phy       (rx_phy),
    .rx_llink     (rx_llink),
    .rx_ar_credit (rx_ar_credit),
    .rx_aw_credit (rx_aw_credit),
    .rx_w_credit  (rx_w_credit)
  );

endmodule

//--- hdl/llink_pkg.sv
////////////////////
// Logic-link definitions for the AXI-MM master concatenator
// Channel payload widths, payload structs and channel ids
////////////////////

package llink_pkg;

  // Payload bits per logic link
  localparam int AR_WIDTH = 47;
  localparam int AW_WIDTH = 47;
  localparam int W_WIDTH  = 39;
  localparam int R_WIDTH  = 37;
  localparam int B_WIDTH  = 4;

  // Request channels sharing the transmit lane
  localparam int NUM_TX_CH = 3;

  // One transmit channel entry.
  // Data is sized for the widest channel, narrower payloads are zero-extended
  typedef struct packed {
    logic [AR_WIDTH-1:0] data;
    logic                push;
  } tx_llink_t;

  // Receive side outputs for the r and b links
  typedef struct packed {
    logic [R_WIDTH-1:0] r_data;
    logic               r_push;
    logic               r_push_ovrd;
    logic [B_WIDTH-1:0] b_data;
    logic               b_push;
    logic               b_push_ovrd;
  } rx_llink_t;

  // Encoded id carried in the transmit word
  typedef enum logic [1:0] {
    TX_CH_AR = 2'd0,
    TX_CH_AW = 2'd1,
    TX_CH_W  = 2'd2
  } tx_ch_e;

  // Encoded id carried in the receive word
  typedef enum logic {
    RX_CH_B = 1'b0,
    RX_CH_R = 1'b1
  } rx_ch_e;

endpackage

//--- hdl/llink_rr_arbiter.sv
////////////////////
// Round-robin arbiter
// Grants the first request at or after a registered priority pointer
////////////////////

module llink_rr_arbiter #(
  parameter int  NUM_REQ  = 3,
  localparam int ID_WIDTH = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
  input  logic                clk_rd,
  input  logic                rst_rd_n,
  input  logic [NUM_REQ-1:0]  request,
  output logic [ID_WIDTH-1:0] grant_id,
  output logic                grant_valid
);

  // Index of the highest priority requester
  logic [ID_WIDTH-1:0] ptr;

  // Scan from the pointer upwards, wrapping at NUM_REQ
  always_comb
  begin
    int idx;
    idx         = 0;
    grant_valid = 1'b0;
    grant_id    = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      idx = int'(ptr) + i;
      if (idx >= NUM_REQ)
      begin
        idx = idx - NUM_REQ;
      end
      if (!grant_valid && request[idx])
      begin
        grant_valid = 1'b1;
        grant_id    = ID_WIDTH'(idx);
      end
    end
  end

  // Granted requester drops to lowest priority
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      ptr <= '0;
    end
    else if (grant_valid)
    begin
      if (grant_id == ID_WIDTH'(NUM_REQ - 1))
      begin
        ptr <= '0;
      end
      else
      begin
        ptr <= grant_id + 1'b1;
      end
    end
  end

endmodule

//--- hdl/phy_pkg.sv
////////////////////
// PHY word layout
// Word and slot widths, field positions of id, slot, credits and marker
////////////////////

package phy_pkg;

  localparam int PHY_WIDTH  = 80;
  localparam int SLOT_WIDTH = 75;

  ////////////////////
  // Transmit word

  // Two-bit channel id at the bottom, then the slot
  localparam int TX_ID_LSB   = 0;
  localparam int TX_SLOT_LSB = 2;

  // Credit returns and marker in the top bits
  localparam int TX_R_CREDIT_BIT = 77;
  localparam int TX_MARKER_BIT   = 78;
  localparam int TX_B_CREDIT_BIT = 79;

  ////////////////////
  // Receive word

  // One-bit channel id, slot directly above
  localparam int RX_ID_BIT   = 0;
  localparam int RX_SLOT_LSB = 1;

  // Credits for the request channels
  localparam int RX_AR_CREDIT_BIT = 76;
  localparam int RX_AW_CREDIT_BIT = 77;
  localparam int RX_W_CREDIT_BIT  = 78;

  // Raw PHY word
  typedef logic [PHY_WIDTH-1:0] phy_word_t;

endpackage

//--- hdl/rx_depacketizer.sv
////////////////////
// Receive depacketizer
// Splits the PHY word into r/b data, push bits, overrides and credits
////////////////////

module rx_depacketizer
  import llink_pkg::*;
  import phy_pkg::*;
#(
  parameter bit REG_PHY = 1'b1
) (
  input  logic      clk_rd,
  input  logic      rst_rd_n,
  input  phy_word_t rx_phy,
  output rx_llink_t rx_llink,
  output logic      rx_ar_credit,
  output logic      rx_aw_credit,
  output logic      rx_w_credit
);

  phy_word_t rx_word;
  rx_ch_e    rx_id;

  // Boundary flop from the PHY
  if (REG_PHY)
  begin : g_rx_reg
    phy_word_t rx_phy_q;

    always_ff @(posedge clk_rd or negedge rst_rd_n)
    begin
      if (!rst_rd_n)
      begin
        rx_phy_q <= '0;
      end
      else
      begin
        rx_phy_q <= rx_phy;
      end
    end

    assign rx_word = rx_phy_q;
  end
  else
  begin : g_rx_comb
    assign rx_word = rx_phy;
  end

  ////////////////////
  // Decode

  assign rx_id = rx_ch_e'(rx_word[RX_ID_BIT]);

  // Data follows the slot whatever the id
  assign rx_llink.r_data = rx_word[RX_SLOT_LSB +: R_WIDTH];
  assign rx_llink.b_data = rx_word[RX_SLOT_LSB +: B_WIDTH];

  // Override low marks the link that owns this word
  assign rx_llink.r_push_ovrd = (rx_id != RX_CH_R);
  assign rx_llink.b_push_ovrd = (rx_id != RX_CH_B);

  // Push bit sits just above each payload
  assign rx_llink.r_push = (rx_id == RX_CH_R) && rx_word[RX_SLOT_LSB + R_WIDTH];
  assign rx_llink.b_push = (rx_id == RX_CH_B) && rx_word[RX_SLOT_LSB + B_WIDTH];

  // Credits for the request channels
  assign rx_ar_credit = rx_word[RX_AR_CREDIT_BIT];
  assign rx_aw_credit = rx_word[RX_AW_CREDIT_BIT];
  assign rx_w_credit  = rx_word[RX_W_CREDIT_BIT];

endmodule

//--- hdl/tx_packetizer.sv
////////////////////
// Transmit packetizer
// Arbitrates ar, aw and w onto one PHY word with credits and marker,
// returns per-channel pop overrides
////////////////////

module tx_packetizer
  import llink_pkg::*;
  import phy_pkg::*;
#(
  parameter bit REG_PHY = 1'b1
) (
  input  logic                 clk_rd,
  input  logic                 rst_rd_n,
  input  tx_llink_t            tx_ar,
  input  tx_llink_t            tx_aw,
  input  tx_llink_t            tx_w,
  input  logic                 tx_r_credit,
  input  logic                 tx_b_credit,
  input  logic                 tx_marker,
  output logic [NUM_TX_CH-1:0] tx_pop_ovrd,
  output phy_word_t            tx_phy
);

  localparam int ID_WIDTH = $bits(tx_ch_e);

  logic [NUM_TX_CH-1:0]  request;
  logic [ID_WIDTH-1:0]   grant_id;
  logic                  grant_valid;
  tx_ch_e                tx_id;
  logic [SLOT_WIDTH-1:0] slot_ar;
  logic [SLOT_WIDTH-1:0] slot_aw;
  logic [SLOT_WIDTH-1:0] slot_w;
  logic [SLOT_WIDTH-1:0] tx_slot;
  phy_word_t             tx_phy_pre;

  // Payload at bit 0, push bit right above it, spare bits zero.
  // Data bits past the channel width are masked off
  function automatic logic [SLOT_WIDTH-1:0] build_slot(input tx_llink_t ch, input int width);
    logic [SLOT_WIDTH-1:0] slot;
    slot = '0;
    for (int i = 0; i < AR_WIDTH; i++)
    begin
      if (i < width)
      begin
        slot[i] = ch.data[i];
      end
    end
    slot[width] = ch.push;
    return slot;
  endfunction

  ////////////////////
  // Arbitration

  // Push bit is the request
  assign request = {tx_w.push, tx_aw.push, tx_ar.push};

  llink_rr_arbiter #(
    .NUM_REQ (NUM_TX_CH)
  ) u_llink_rr_arbiter (
    .clk_rd      (clk_rd),
    .rst_rd_n    (rst_rd_n),
    .request     (request),
    .grant_id    (grant_id),
    .grant_valid (grant_valid)
  );

  // Idle lane sends an empty ar slot
  assign tx_id = grant_valid ? tx_ch_e'(grant_id) : TX_CH_AR;

  // Only the channel on the lane may pop
  always_comb
  begin
    for (int i = 0; i < NUM_TX_CH; i++)
    begin
      tx_pop_ovrd[i] = (int'(tx_id) != i);
    end
  end

  ////////////////////
  // Slot build and select

  assign slot_ar = build_slot(tx_ar, AR_WIDTH);
  assign slot_aw = build_slot(tx_aw, AW_WIDTH);
  assign slot_w  = build_slot(tx_w, W_WIDTH);

  always_comb
  begin
    case (tx_id)
      TX_CH_AR: tx_slot = slot_ar;
      TX_CH_AW: tx_slot = slot_aw;
      TX_CH_W:  tx_slot = slot_w;
      default:  tx_slot = '0;
    endcase
  end

  ////////////////////
  // PHY word

  always_comb
  begin
    tx_phy_pre                                = '0;
    tx_phy_pre[TX_ID_LSB +: ID_WIDTH]         = tx_id;
    tx_phy_pre[TX_SLOT_LSB +: SLOT_WIDTH]     = tx_slot;
    tx_phy_pre[TX_R_CREDIT_BIT]               = tx_r_credit;
    tx_phy_pre[TX_MARKER_BIT]                 = tx_marker;
    tx_phy_pre[TX_B_CREDIT_BIT]               = tx_b_credit;
  end

  // Boundary flop toward the PHY
  if (REG_PHY)
  begin : g_tx_reg
    phy_word_t tx_phy_q;

    always_ff @(posedge clk_rd or negedge rst_rd_n)
    begin
      if (!rst_rd_n)
      begin
        tx_phy_q <= '0;
      end
      else
      begin
        tx_phy_q <= tx_phy_pre;
      end
    end

    assign tx_phy = tx_phy_q;
  end
  else
  begin : g_tx_comb
    assign tx_phy = tx_phy_pre;
  end

endmodule

//--- tests/axi_mm_master_concat_assert.sv
////////////////////
// Concurrent checks for the concatenator
// Bound into the packetizer and the depacketizer
////////////////////

module axi_mm_master_concat_assert
  import llink_pkg::*;
(
  input logic                 clk_rd,
  input logic                 rst_rd_n,
  input logic [NUM_TX_CH-1:0] tx_pop_ovrd,
  input logic [NUM_TX_CH-1:0] request,
  input logic [1:0]           tx_id,
  input rx_llink_t            rx_llink
);

  // One channel pops per cycle at most
  pop_single_low: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    $countones(~tx_pop_ovrd) <= 1)
  else $error("more than one pop override is low");

  // A busy lane always carries a requesting channel
  grant_has_push: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    (|request) |-> request[tx_id])
  else $error("granted channel has no push bit while another channel requests");

  // Receive word belongs to r or b, never both
  rx_push_exclusive: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !(rx_llink.r_push && rx_llink.b_push))
  else $error("r and b push bits are high together");

endmodule

bind tx_packetizer axi_mm_master_concat_assert u_tx_assert (
  .clk_rd      (clk_rd),
  .rst_rd_n    (rst_rd_n),
  .tx_pop_ovrd (tx_pop_ovrd),
  .request     (request),
  .tx_id       (tx_id),
  .rx_llink    ('0)
);

bind rx_depacketizer axi_mm_master_concat_assert u_rx_assert (
  .clk_rd      (clk_rd),
  .rst_rd_n    (rst_rd_n),
  .tx_pop_ovrd ('1),
  .request     ('0),
  .tx_id       ('0),
  .rx_llink    (rx_llink)
);

//--- tests/tb_axi_mm_master_concat.sv
////////////////////
// Testbench for the AXI-MM master concatenator
// Table-driven stimulus against a round-robin and layout model
////////////////////

module tb_axi_mm_master_concat
  import llink_pkg::*;
  import phy_pkg::*;
();

  typedef struct packed {
    logic [NUM_TX_CH-1:0] push;
    logic                 r_credit;
    logic                 b_credit;
    logic                 marker;
    logic [AR_WIDTH-1:0]  ar_data;
    logic [AW_WIDTH-1:0]  aw_data;
    logic [W_WIDTH-1:0]   w_data;
    phy_word_t            rx_phy;
  } row_t;

  logic clk_rd, rst_rd_n;
  tx_llink_t tx_ar, tx_aw, tx_w;
  logic [NUM_TX_CH-1:0] tx_pop_ovrd;
  logic tx_r_credit, tx_b_credit, tx_marker;
  phy_word_t tx_phy, rx_phy;
  rx_llink_t rx_llink;
  logic rx_ar_credit, rx_aw_credit, rx_w_credit;

  row_t  rows[$];
  string names[$];
  int    ptr_model;
  int    cycle_count = 0;

  tb_clk_gen u_tb_clk_gen (.clk_rd(clk_rd), .rst_rd_n(rst_rd_n));

  axi_mm_master_concat #(
    .TX_REG_PHY (1'b1),
    .RX_REG_PHY (1'b1)
  ) u_axi_mm_master_concat (
    .clk_rd       (clk_rd),
    .rst_rd_n     (rst_rd_n),
    .tx_ar        (tx_ar),
    .tx_aw        (tx_aw),
    .tx_w         (tx_w),
    .tx_pop_ovrd  (tx_pop_ovrd),
    .tx_r_credit  (tx_r_credit),
    .tx_b_credit  (tx_b_credit),
    .tx_marker    (tx_marker),
    .tx_phy       (tx_phy),
    .rx_phy       (rx_phy),
    .rx_llink     (rx_llink),
    .rx_ar_credit (rx_ar_credit),
    .rx_aw_credit (rx_aw_credit),
    .rx_w_credit  (rx_w_credit)
  );

  function automatic logic [95:0] random_bits();
    return {$urandom(), $urandom(), $urandom()};
  endfunction

  task automatic add_row(input string base, input logic [2:0] push, input logic [2:0] side);
    row_t row;
    row.push    = push;
    {row.r_credit, row.b_credit, row.marker} = side;
    row.ar_data = random_bits() >> (96 - AR_WIDTH);
    row.aw_data = random_bits() >> (96 - AW_WIDTH);
    row.w_data  = random_bits() >> (96 - W_WIDTH);
    row.rx_phy  = random_bits() >> (96 - PHY_WIDTH);
    names.push_back($sformatf("%s_%0d", base, names.size()));
    rows.push_back(row);
  endtask

  // First requester at or after the pointer, -1 when idle
  function automatic int pick_grant(input logic [2:0] push, input int ptr);
    int ch;
    for (int k = 0; k < NUM_TX_CH; k++)
    begin
      ch = (ptr + k) % NUM_TX_CH;
      if (push[ch])
        return ch;
    end
    return -1;
  endfunction

  // Payload at bit 0, push bit on top, zero spare
  function automatic phy_word_t expected_tx(input row_t row, input int id);
    logic [SLOT_WIDTH-1:0] slot;
    case (id)
      1:       slot = SLOT_WIDTH'({row.push[1], row.aw_data});
      2:       slot = SLOT_WIDTH'({row.push[2], row.w_data});
      default: slot = SLOT_WIDTH'({row.push[0], row.ar_data});
    endcase
    return {row.b_credit, row.marker, row.r_credit, slot, 2'(id)};
  endfunction

  function automatic rx_llink_t expected_rx(input phy_word_t word);
    rx_llink_t             result;
    logic                  is_r;
    logic [SLOT_WIDTH-1:0] slot;
    is_r               = word[0];
    slot               = word[SLOT_WIDTH:1];
    result.r_data      = slot[R_WIDTH-1:0];
    result.r_push      = is_r & slot[R_WIDTH];
    result.r_push_ovrd = ~is_r;
    result.b_data      = slot[B_WIDTH-1:0];
    result.b_push      = ~is_r & slot[B_WIDTH];
    result.b_push_ovrd = is_r;
    return result;
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [PHY_WIDTH-1:0] expected,
                             input logic [PHY_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test, field, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_outputs(input string test, input phy_word_t exp_tx,
                               input rx_llink_t exp_rx, input logic [2:0] exp_cred);
    check_value(test, "tx_phy", exp_tx, tx_phy);
    check_value(test, "rx_llink", PHY_WIDTH'(exp_rx), PHY_WIDTH'(rx_llink));
    check_value(test, "rx_credits", PHY_WIDTH'(exp_cred),
                PHY_WIDTH'({rx_w_credit, rx_aw_credit, rx_ar_credit}));
  endtask

  task automatic drive_row(input row_t row);
    tx_ar       = '{data: row.ar_data, push: row.push[0]};
    tx_aw       = '{data: row.aw_data, push: row.push[1]};
    tx_w        = '{data: AR_WIDTH'(row.w_data), push: row.push[2]};
    tx_r_credit = row.r_credit;
    tx_b_credit = row.b_credit;
    tx_marker   = row.marker;
    rx_phy      = row.rx_phy;
  endtask

  // Run limit follows the table length
  always @(posedge clk_rd)
  begin
    cycle_count++;
    if (cycle_count > rows.size() + 20)
    begin
      $display("Timeout after %0d cycles, the table did not finish", cycle_count);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    row_t       row;
    phy_word_t  exp_tx;
    rx_llink_t  exp_rx;
    logic [2:0] exp_cred;
    logic [2:0] exp_pop;
    string      prev_name;
    int         grant;
    int         id;
    // Busy inputs while reset is held
    row = '1;
    drive_row(row);
    void'($urandom(79));

    ////////////////////
    // Stimulus table
    for (int i = 0; i < 4; i++)
      add_row("rotation", 3'b111, 3'b000);
    add_row("contention", 3'b101, 3'b000);
    add_row("contention", 3'b011, 3'b000);
    add_row("contention", 3'b110, 3'b000);
    add_row("contention", 3'b010, 3'b000);
    add_row("contention", 3'b100, 3'b000);
    add_row("contention", 3'b001, 3'b000);
    add_row("contention", 3'b101, 3'b000);
    add_row("contention", 3'b110, 3'b000);
    add_row("idle", 3'b000, 3'b000);
    add_row("idle", 3'b000, 3'b000);
    add_row("passthru", 3'b010, 3'b101);
    add_row("passthru", 3'b000, 3'b010);
    add_row("passthru", 3'b100, 3'b111);
    add_row("passthru", 3'b001, 3'b001);
    for (int i = 0; i < 6; i++)
      add_row("rx_decode", 3'($urandom()), 3'($urandom()));

    // Expected state straight out of reset
    ptr_model = 0;
    exp_tx    = '0;
    exp_rx    = expected_rx('0);
    exp_cred  = 3'b000;
    prev_name = "reset";
    @(posedge rst_rd_n);
    // Flops held in reset must not have taken the busy inputs
    check_outputs(prev_name, exp_tx, exp_rx, exp_cred);

    // Quiet inputs for the first clock after release
    row = '0;
    drive_row(row);

    for (int i = 0; i < rows.size(); i++)
    begin
      @(negedge clk_rd);
      check_outputs(prev_name, exp_tx, exp_rx, exp_cred);
      row = rows[i];
      drive_row(row);
      #1;
      grant   = pick_grant(row.push, ptr_model);
      id      = (grant < 0) ? 0 : grant;
      exp_pop = 3'b111;
      exp_pop[id] = 1'b0;
      check_value(names[i], "tx_pop_ovrd", PHY_WIDTH'(exp_pop), PHY_WIDTH'(tx_pop_ovrd));
      // Registered outputs show this row one clock later
      exp_tx    = expected_tx(row, id);
      exp_rx    = expected_rx(row.rx_phy);
      exp_cred  = {row.rx_phy[78], row.rx_phy[77], row.rx_phy[76]};
      prev_name = names[i];
      if (grant >= 0)
        ptr_model = (grant + 1) % NUM_TX_CH;
    end
    @(negedge clk_rd);
    check_outputs(prev_name, exp_tx, exp_rx, exp_cred);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- tests/tb_clk_gen.sv
////////////////////
// Testbench clock and reset
////////////////////

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_rd,
  output logic rst_rd_n
);

  initial
  begin
    clk_rd = 1'b0;
    forever #HALF_PERIOD clk_rd = ~clk_rd;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_rd_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_rd);
    @(negedge clk_rd);
    rst_rd_n = 1'b1;
  end

endmodule

//--- verilog.f
hdl/llink_pkg.sv
hdl/phy_pkg.sv
hdl/llink_rr_arbiter.sv
hdl/tx_packetizer.sv
hdl/rx_depacketizer.sv
hdl/axi_mm_master_concat.sv
tests/tb_clk_gen.sv
tests/axi_mm_master_concat_assert.sv
tests/tb_axi_mm_master_concat.sv
